// ==== gat_config.svh ====
// ==============================
// GAT feature-by-weight stage
// Widths and depths shared by the
// memories, weight bank and engine
// ==============================

`ifndef GAT_CONFIG_SVH
`define GAT_CONFIG_SVH

// Feature and weight width
`define GAT_DATA_WIDTH       8
// Accumulator and Wh element width
`define GAT_WH_DATA_WIDTH    16

// Matrix shape
`define GAT_NUM_FEATURE_IN   8
`define GAT_NUM_FEATURE_OUT  4

// Subgraph limits
`define GAT_MAX_NODES        8
`define GAT_NUM_SUBGRAPHS    8

// Memory depths
`define GAT_FEAT_DEPTH       512
`define GAT_WH_DEPTH         64

`endif

// ==== gat_pkg.sv ====
// ==============================
// GAT shared types
// Data, address and state types for
// the Wh stage
// ==============================

`include "gat_config.svh"

package gat_pkg;

  // Data words
  typedef logic signed [`GAT_DATA_WIDTH-1:0]    feat_t;
  typedef logic signed [`GAT_WH_DATA_WIDTH-1:0] wh_elem_t;

  // One output row, lane 0 in the top bits
  typedef logic [`GAT_NUM_FEATURE_OUT*`GAT_WH_DATA_WIDTH-1:0] wh_row_t;
  typedef logic [$clog2(`GAT_MAX_NODES+1)-1:0]               num_node_t;

  // Stored result: row, node count, source flag at bit 0
  typedef logic [$bits(wh_row_t)+$bits(num_node_t):0] wh_word_t;

  // Addresses
  typedef logic [$clog2(`GAT_FEAT_DEPTH)-1:0]    feat_addr_t;
  typedef logic [$clog2(`GAT_NUM_SUBGRAPHS)-1:0] sg_addr_t;
  typedef logic [$clog2(`GAT_WH_DEPTH)-1:0]      wh_addr_t;

  // All lane weights of one input feature, lane 0 on top
  typedef logic [`GAT_NUM_FEATURE_OUT*`GAT_DATA_WIDTH-1:0] weight_row_t;

  typedef enum logic [1:0] {IDLE, RUN, DRAIN, DONE} wh_state_t;

endpackage

// ==== gat_sdp_ram.sv ====
// ==============================
// Simple dual-port RAM
// Synchronous write, registered read
// with one cycle of latency
// ==============================

`timescale 1ns/10ps

module gat_sdp_ram #(
  parameter int DATA_W = 8,
  parameter int DEPTH  = 256
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  logic [DATA_W-1:0]        wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output logic [DATA_W-1:0]        rdata
);

  logic [DATA_W-1:0] mem [DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Read port, output register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else begin
      rdata <= mem[raddr];
    end
  end

endmodule

// ==== weight_bank.sv ====
// ==============================
// Weight bank
// Flop array of W with single-weight
// writes and a full-row parallel read
// ==============================

`timescale 1ns/10ps
`include "gat_config.svh"

module weight_bank (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    we,
  input  logic [$clog2(`GAT_NUM_FEATURE_IN)-1:0]  row,
  input  logic [$clog2(`GAT_NUM_FEATURE_OUT)-1:0] col,
  input  gat_pkg::feat_t                          wdata,
  input  logic [$clog2(`GAT_NUM_FEATURE_IN)-1:0]  rd_row,
  output gat_pkg::weight_row_t                    rd_data
);
  import gat_pkg::*;

  localparam int NFI = `GAT_NUM_FEATURE_IN;
  localparam int NFO = `GAT_NUM_FEATURE_OUT;
  localparam int DW  = `GAT_DATA_WIDTH;

  // Row index is the input feature, column is the output lane
  feat_t w_q [NFI][NFO];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < NFI; r++) begin
        for (int c = 0; c < NFO; c++) begin
          w_q[r][c] <= '0;
        end
      end
    end else if (we) begin
      w_q[row][col] <= wdata;
    end
  end

  // All lanes of one feature at once, lane 0 on top
  always_comb begin
    for (int c = 0; c < NFO; c++) begin
      rd_data[(NFO-1-c)*DW +: DW] = w_q[rd_row][c];
    end
  end

endmodule

// ==== wh_engine.sv ====
// ==============================
// Wh engine
// Walks subgraphs, nodes and features,
// runs the MAC lanes for Wh = H x W and
// emits one tagged row per node
// ==============================

`timescale 1ns/10ps
`include "gat_config.svh"

module wh_engine (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   start,
  input  logic [$bits(gat_pkg::sg_addr_t):0]     num_subgraphs,
  output logic                                   busy,
  output logic                                   done,
  output gat_pkg::feat_addr_t                    feat_raddr,
  input  gat_pkg::feat_t                         feat_rdata,
  output gat_pkg::sg_addr_t                      nn_raddr,
  input  gat_pkg::num_node_t                     nn_rdata,
  output logic [$clog2(`GAT_NUM_FEATURE_IN)-1:0] w_rd_row,
  input  gat_pkg::weight_row_t                   w_rd_data,
  output logic                                   wh_valid,
  output gat_pkg::wh_word_t                      wh_data,
  output gat_pkg::wh_addr_t                      wh_waddr
);
  import gat_pkg::*;

  localparam int NFI   = `GAT_NUM_FEATURE_IN;
  localparam int NFO   = `GAT_NUM_FEATURE_OUT;
  localparam int IDX_W = $clog2(NFI);
  localparam int DW    = `GAT_DATA_WIDTH;
  localparam int WHW   = `GAT_WH_DATA_WIDTH;

  wh_state_t                   state;
  wh_state_t                   state_nxt;
  logic [$bits(sg_addr_t):0]   num_sg_q;
  sg_addr_t                    sg_idx;
  num_node_t                   node_cnt;
  logic [IDX_W-1:0]            feat_idx;
  logic                        launch;
  logic                        issue;
  logic                        row_end;
  logic                        sg_end;
  logic                        run_end;
  // Pipeline markers
  logic                        vld_d1;
  logic                        vld_d2;
  logic                        last_d1;
  logic                        last_d2;
  logic [IDX_W-1:0]            idx_d1;
  logic [IDX_W-1:0]            idx_d2;
  // Datapath
  feat_t                       feat_q;
  feat_t                       w_lane [NFO];
  wh_elem_t                    prod [NFO];
  wh_elem_t                    acc [NFO];
  wh_row_t                     wh_row;
  num_node_t                   num_node_d1;
  num_node_t                   num_node_d2;
  num_node_t                   num_node_q;
  logic                        src_d1;
  logic                        src_d2;
  logic                        src_q;

  // ==============================
  // Sequencer
  // ==============================
  assign launch  = start && ((state == IDLE) || (state == DONE));
  assign issue   = (state == RUN);
  assign row_end = (feat_idx == IDX_W'(NFI - 1));
  assign sg_end  = row_end && (node_cnt == nn_rdata - 1'b1);
  assign run_end = sg_end && ({1'b0, sg_idx} == num_sg_q - 1'b1);

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE, DONE: begin
        if (start) begin
          // Nothing to walk for an empty batch
          state_nxt = (num_subgraphs == '0) ? DONE : RUN;
        end else begin
          state_nxt = IDLE;
        end
      end
      RUN:     if (run_end) state_nxt = DRAIN;
      // Last row out and nothing left behind it
      DRAIN:   if (wh_valid && !vld_d1 && !vld_d2) state_nxt = DONE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE;
      num_sg_q   <= '0;
      sg_idx     <= '0;
      node_cnt   <= '0;
      feat_idx   <= '0;
      feat_raddr <= '0;
    end else begin
      state <= state_nxt;
      if (launch) begin
        num_sg_q   <= num_subgraphs;
        sg_idx     <= '0;
        node_cnt   <= '0;
        feat_idx   <= '0;
        feat_raddr <= '0;
      end else if (issue) begin
        feat_raddr <= feat_raddr + 1'b1;
        if (row_end) begin
          feat_idx <= '0;
          if (sg_end) begin
            node_cnt <= '0;
            sg_idx   <= sg_idx + 1'b1;
          end else begin
            node_cnt <= node_cnt + 1'b1;
          end
        end else begin
          feat_idx <= feat_idx + 1'b1;
        end
      end
    end
  end

  assign nn_raddr = sg_idx;
  assign busy     = (state == RUN) || (state == DRAIN);
  assign done     = (state == DONE);

  // ==============================
  // Row markers and write address
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_d1   <= 1'b0;
      vld_d2   <= 1'b0;
      last_d1  <= 1'b0;
      last_d2  <= 1'b0;
      idx_d1   <= '0;
      idx_d2   <= '0;
      wh_valid <= 1'b0;
      wh_waddr <= '0;
    end else begin
      vld_d1   <= issue;
      vld_d2   <= vld_d1;
      last_d1  <= issue && row_end;
      last_d2  <= last_d1;
      idx_d1   <= feat_idx;
      idx_d2   <= idx_d1;
      wh_valid <= last_d2;
      if (launch) begin
        wh_waddr <= '0;
      end else if (wh_valid) begin
        wh_waddr <= wh_waddr + 1'b1;
      end
    end
  end

  // ==============================
  // MAC lanes
  // ==============================
  assign w_rd_row = idx_d2;

  always_comb begin
    for (int j = 0; j < NFO; j++) begin
      w_lane[j] = w_rd_data[(NFO-1-j)*DW +: DW];
      prod[j]   = feat_q * w_lane[j];
    end
  end

  always_ff @(posedge clk) begin
    feat_q      <= feat_rdata;
    // Tag sampled at stage 0, where nn_rdata belongs to the current subgraph
    num_node_d1 <= nn_rdata;
    src_d1      <= (node_cnt == '0);
    num_node_d2 <= num_node_d1;
    src_d2      <= src_d1;
    if (last_d2) begin
      num_node_q <= num_node_d2;
      src_q      <= src_d2;
    end
    if (vld_d2) begin
      for (int j = 0; j < NFO; j++) begin
        // Restart on feature 0, otherwise wrap-around accumulate
        acc[j] <= (idx_d2 == '0) ? prod[j] : wh_elem_t'(acc[j] + prod[j]);
      end
    end
  end

  always_comb begin
    for (int j = 0; j < NFO; j++) begin
      wh_row[(NFO-1-j)*WHW +: WHW] = acc[j];
    end
  end

  assign wh_data = {wh_row, num_node_q, src_q};

endmodule

// ==== wh_top.sv ====
// ==============================
// Wh stage top level
// Feature, node-count and Wh memories,
// weight bank and the Wh engine
// ==============================

`timescale 1ns/10ps
`include "gat_config.svh"

module wh_top (
  input  logic                                    clk,
  input  logic                                    rst_n,
  // Feature memory write
  input  logic                                    feat_we,
  input  gat_pkg::feat_addr_t                     feat_waddr,
  input  gat_pkg::feat_t                          feat_wdata,
  // Node-count memory write
  input  logic                                    nn_we,
  input  gat_pkg::sg_addr_t                       nn_waddr,
  input  gat_pkg::num_node_t                      nn_wdata,
  // Weight bank write
  input  logic                                    w_we,
  input  logic [$clog2(`GAT_NUM_FEATURE_IN)-1:0]  w_row,
  input  logic [$clog2(`GAT_NUM_FEATURE_OUT)-1:0] w_col,
  input  gat_pkg::feat_t                          w_wdata,
  // Control
  input  logic                                    start,
  input  logic [$bits(gat_pkg::sg_addr_t):0]      num_subgraphs,
  output logic                                    busy,
  output logic                                    done,
  // Result stream and readback
  output logic                                    wh_valid,
  output gat_pkg::wh_word_t                       wh_data,
  input  gat_pkg::wh_addr_t                       wh_raddr,
  output gat_pkg::wh_word_t                       wh_rdata
);
  import gat_pkg::*;

  feat_addr_t                           feat_raddr;
  feat_t                                feat_rdata;
  sg_addr_t                             nn_raddr;
  num_node_t                            nn_rdata;
  logic [$clog2(`GAT_NUM_FEATURE_IN)-1:0] w_rd_row;
  weight_row_t                          w_rd_data;
  wh_addr_t                             wh_waddr;

  // ==============================
  // Input stores
  // ==============================
  gat_sdp_ram #(
    .DATA_W ($bits(feat_t)),
    .DEPTH  (`GAT_FEAT_DEPTH)
  ) feat_mem_i (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (feat_we),
    .waddr (feat_waddr),
    .wdata (feat_wdata),
    .raddr (feat_raddr),
    .rdata (feat_rdata)
  );

  gat_sdp_ram #(
    .DATA_W ($bits(num_node_t)),
    .DEPTH  (`GAT_NUM_SUBGRAPHS)
  ) nn_mem_i (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (nn_we),
    .waddr (nn_waddr),
    .wdata (nn_wdata),
    .raddr (nn_raddr),
    .rdata (nn_rdata)
  );

  weight_bank weight_bank_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .we      (w_we),
    .row     (w_row),
    .col     (w_col),
    .wdata   (w_wdata),
    .rd_row  (w_rd_row),
    .rd_data (w_rd_data)
  );

  // ==============================
  // Engine and result store
  // ==============================
  wh_engine wh_engine_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .start         (start),
    .num_subgraphs (num_subgraphs),
    .busy          (busy),
    .done          (done),
    .feat_raddr    (feat_raddr),
    .feat_rdata    (feat_rdata),
    .nn_raddr      (nn_raddr),
    .nn_rdata      (nn_rdata),
    .w_rd_row      (w_rd_row),
    .w_rd_data     (w_rd_data),
    .wh_valid      (wh_valid),
    .wh_data       (wh_data),
    .wh_waddr      (wh_waddr)
  );

  // Each strobed row lands at the next Wh address
  gat_sdp_ram #(
    .DATA_W ($bits(wh_word_t)),
    .DEPTH  (`GAT_WH_DEPTH)
  ) wh_mem_i (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (wh_valid),
    .waddr (wh_waddr),
    .wdata (wh_data),
    .raddr (wh_raddr),
    .rdata (wh_rdata)
  );

endmodule

// ==== tb_wh_top.sv ====
// ==============================
// Wh stage testbench
// Table-driven runs of Wh = H x W,
// checked against a dot-product model
// ==============================

`timescale 1ns/10ps
`include "gat_config.svh"

module tb_wh_top;
  import gat_pkg::*;

  localparam int NFI       = `GAT_NUM_FEATURE_IN;
  localparam int NFO       = `GAT_NUM_FEATURE_OUT;
  localparam int WHW       = `GAT_WH_DATA_WIDTH;
  localparam int ROW_W     = $clog2(NFI);
  localparam int COL_W     = $clog2(NFO);
  localparam int TAG_W     = $bits(num_node_t) + 1;
  localparam int WORD_W    = $bits(wh_word_t);
  localparam int NUM_TESTS = 6;

  typedef enum logic [1:0] {MODE_RAND, MODE_MAX, MODE_MIN} data_mode_t;

  // Node counts with subgraph 0 in the low nibble
  typedef struct packed {
    logic [3:0]  num_sg;
    logic [31:0] counts;
    data_mode_t  mode;
  } test_case_t;

  logic                      clk;
  logic                      rst_n;
  logic                      feat_we;
  feat_addr_t                feat_waddr;
  feat_t                     feat_wdata;
  logic                      nn_we;
  sg_addr_t                  nn_waddr;
  num_node_t                 nn_wdata;
  logic                      w_we;
  logic [ROW_W-1:0]          w_row;
  logic [COL_W-1:0]          w_col;
  feat_t                     w_wdata;
  logic                      start;
  logic [$bits(sg_addr_t):0] num_subgraphs;
  logic                      busy;
  logic                      done;
  logic                      wh_valid;
  wh_word_t                  wh_data;
  wh_addr_t                  wh_raddr;
  wh_word_t                  wh_rdata;

  // Reference copies of what the host wrote
  test_case_t tests [NUM_TESTS];
  feat_t      feat_ref [`GAT_FEAT_DEPTH];
  feat_t      w_ref [NFI][NFO];
  wh_word_t   exp_word [`GAT_WH_DEPTH];
  int         num_nodes;
  int         test_err;
  int         err_cnt;
  int         fail_cnt;

  wh_top dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .feat_we       (feat_we),
    .feat_waddr    (feat_waddr),
    .feat_wdata    (feat_wdata),
    .nn_we         (nn_we),
    .nn_waddr      (nn_waddr),
    .nn_wdata      (nn_wdata),
    .w_we          (w_we),
    .w_row         (w_row),
    .w_col         (w_col),
    .w_wdata       (w_wdata),
    .start         (start),
    .num_subgraphs (num_subgraphs),
    .busy          (busy),
    .done          (done),
    .wh_valid      (wh_valid),
    .wh_data       (wh_data),
    .wh_raddr      (wh_raddr),
    .wh_rdata      (wh_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==============================
  // Helpers and reference model
  // ==============================
  task automatic check_value(string name, logic [WORD_W-1:0] expv, logic [WORD_W-1:0] actv);
    assert (actv === expv) else begin
      $display("ERR %0t %s expected 0x%0h actual 0x%0h", $time, name, expv, actv);
      test_err++;
    end
  endtask

  function automatic int count_nodes(test_case_t tc);
    int total;
    total = 0;
    for (int s = 0; s < tc.num_sg; s++) begin
      total += tc.counts[s*4 +: 4];
    end
    return total;
  endfunction

  function automatic feat_t pick_value(data_mode_t mode);
    case (mode)
      MODE_MAX: return feat_t'(8'h7f);
      MODE_MIN: return feat_t'(8'h80);
      default:  return feat_t'($urandom);
    endcase
  endfunction

  // Signed dot product per lane wrapped to the element width
  function automatic wh_word_t ref_word(int node, int cnt, bit src);
    wh_row_t row;
    int      sum;
    for (int j = 0; j < NFO; j++) begin
      sum = 0;
      for (int k = 0; k < NFI; k++) begin
        sum += int'(feat_ref[node*NFI + k]) * int'(w_ref[k][j]);
      end
      row[(NFO-1-j)*WHW +: WHW] = sum[WHW-1:0];
    end
    return {row, num_node_t'(cnt), src};
  endfunction

  // ==============================
  // Test steps
  // ==============================
  task automatic load_case(test_case_t tc);
    int node;
    num_nodes = count_nodes(tc);
    for (int k = 0; k < NFI; k++) begin
      for (int j = 0; j < NFO; j++) begin
        w_ref[k][j] = pick_value(tc.mode);
        @(posedge clk);
        w_we    <= 1'b1;
        w_row   <= ROW_W'(k);
        w_col   <= COL_W'(j);
        w_wdata <= w_ref[k][j];
      end
    end
    @(posedge clk);
    w_we <= 1'b0;
    for (int s = 0; s < tc.num_sg; s++) begin
      @(posedge clk);
      nn_we    <= 1'b1;
      nn_waddr <= sg_addr_t'(s);
      nn_wdata <= tc.counts[s*4 +: 4];
    end
    @(posedge clk);
    nn_we <= 1'b0;
    // H rows back to back
    for (int a = 0; a < num_nodes * NFI; a++) begin
      feat_ref[a] = pick_value(tc.mode);
      @(posedge clk);
      feat_we    <= 1'b1;
      feat_waddr <= feat_addr_t'(a);
      feat_wdata <= feat_ref[a];
    end
    @(posedge clk);
    feat_we <= 1'b0;
    node = 0;
    for (int s = 0; s < tc.num_sg; s++) begin
      for (int i = 0; i < tc.counts[s*4 +: 4]; i++) begin
        exp_word[node] = ref_word(node, tc.counts[s*4 +: 4], i == 0);
        node++;
      end
    end
  endtask

  task automatic run_case(test_case_t tc);
    int cyc;
    int node;
    int last_cyc;
    @(posedge clk);
    start         <= 1'b1;
    num_subgraphs <= tc.num_sg;
    @(negedge clk);
    check_value("busy in start cycle", WORD_W'(1'b0), WORD_W'(busy));
    @(posedge clk);
    start    <= 1'b0;
    cyc      = 0;
    node     = 0;
    last_cyc = -1;
    // Cycle numbers count from the start cycle
    do begin
      @(negedge clk);
      cyc++;
      if (cyc == 1) begin
        check_value("busy", WORD_W'(1'b1), WORD_W'(busy));
      end
      if (wh_valid) begin
        assert (node < num_nodes) else begin
          $display("wh_valid strobed more often than there are nodes at %0t", $time);
          test_err++;
        end
        if (node < num_nodes) begin
          check_value("wh_valid cycle", WORD_W'((node + 1) * NFI + 3), WORD_W'(cyc));
          for (int j = 0; j < NFO; j++) begin
            check_value($sformatf("wh_data lane %0d", j),
                        WORD_W'(exp_word[node][TAG_W + (NFO-1-j)*WHW +: WHW]),
                        WORD_W'(wh_data[TAG_W + (NFO-1-j)*WHW +: WHW]));
          end
          check_value("wh_data num_node", WORD_W'(exp_word[node][TAG_W-1:1]),
                      WORD_W'(wh_data[TAG_W-1:1]));
          check_value("wh_data src", WORD_W'(exp_word[node][0]), WORD_W'(wh_data[0]));
        end
        node++;
        last_cyc = cyc;
      end
    end while (!done);
    check_value("wh_valid count", WORD_W'(num_nodes), WORD_W'(node));
    check_value("done cycle", WORD_W'(last_cyc + 1), WORD_W'(cyc));
  endtask

  task automatic read_back();
    for (int i = 0; i < num_nodes; i++) begin
      @(posedge clk);
      wh_raddr <= wh_addr_t'(i);
      @(posedge clk);
      @(negedge clk);
      check_value($sformatf("wh_rdata[%0d]", i), exp_word[i], wh_rdata);
    end
  endtask

  // ==============================
  // Main sequence
  // ==============================
  initial begin
    void'($urandom(32'hccb78d52));
    tests[0] = '{4'd1, 32'h0000_0003, MODE_RAND};
    tests[1] = '{4'd3, 32'h0000_0241, MODE_RAND};
    tests[2] = '{4'd8, 32'h8888_8888, MODE_RAND};
    tests[3] = '{4'd2, 32'h0000_0058, MODE_MAX};
    tests[4] = '{4'd2, 32'h0000_0032, MODE_MIN};
    tests[5] = '{4'd4, 32'h0000_1111, MODE_RAND};
    rst_n         = 1'b0;
    feat_we       = 1'b0;
    feat_waddr    = '0;
    feat_wdata    = '0;
    nn_we         = 1'b0;
    nn_waddr      = '0;
    nn_wdata      = '0;
    w_we          = 1'b0;
    w_row         = '0;
    w_col         = '0;
    w_wdata       = '0;
    start         = 1'b0;
    num_subgraphs = '0;
    wh_raddr      = '0;
    test_err      = 0;
    err_cnt       = 0;
    fail_cnt      = 0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("busy", WORD_W'(1'b0), WORD_W'(busy));
    check_value("done", WORD_W'(1'b0), WORD_W'(done));
    check_value("wh_valid", WORD_W'(1'b0), WORD_W'(wh_valid));
    $display("reset check: %0d errors", test_err);
    err_cnt = test_err;
    if (test_err != 0) fail_cnt++;
    // No reset between table entries
    for (int t = 0; t < NUM_TESTS; t++) begin
      test_err = 0;
      load_case(tests[t]);
      run_case(tests[t]);
      read_back();
      $display("test %0d: %0d subgraphs, %0d nodes, %0d errors",
               t, tests[t].num_sg, num_nodes, test_err);
      if (test_err != 0) fail_cnt++;
      err_cnt += test_err;
    end
    $display("tests run %0d, tests failed %0d, errors %0d", NUM_TESTS, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // Four cycles per feature for load, run and readback plus a margin per test
  initial begin : watchdog
    longint limit;
    int     total;
    @(posedge rst_n);
    total = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      total += count_nodes(tests[t]) * NFI;
    end
    limit = (longint'(total) * 4 + NUM_TESTS * 200) * 100;
    #(limit);
    $display("watchdog expired at %0t before all tests finished", $time);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+.
gat_pkg.sv
gat_sdp_ram.sv
weight_bank.sv
wh_engine.sv
wh_top.sv
tb_wh_top.sv
